// File: Bender.yml
package:
  name: attn_bridge

sources:
  - files:
      - source/attn_fixed_pkg.sv
      - source/attn_layout_pkg.sv
      - source/linear_projection.sv
      - source/bridge_buffer.sv
      - source/score_matmul.sv
      - source/score_rshift.sv
      - source/attn_bridge_top.sv
  - target: test
    files:
      - dv/tb_attn_bridge.sv

// File: dv/tb_attn_bridge.sv
// --------------------------------------------------
// Attention bridge testbench: reference model,
// xorshift data, directed tests, check and timeout
// --------------------------------------------------
module tb_attn_bridge
    import attn_fixed_pkg::*, attn_layout_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int feed_gap     = 0;
    localparam int half_period  = 4;
    localparam int reset_cycles = 10;
    // Six tests, about 50 cycles each on average
    localparam int cycle_limit  = reset_cycles + 6 * 50;
    // Last row is due 22 cycles after start
    localparam int row_wait     = 40;
    // Cycle of the final feed beat, counted from the start edge
    localparam int last_beat    = num_tokens + num_tokens * num_feat
                                  + (num_tokens - 1) * feed_gap;

    logic       clk;
    logic       rst_n;
    logic       start;
    wr_cmd_t    wr_a;
    wr_cmd_t    wr_b;
    logic       busy;
    score_row_t out_scores;

    logic [31:0] rng_state = 32'd77233;
    int          cyc = 0;
    int          start_cyc = 0;
    score_row_t  rows_q [$];
    int          row_cyc_q [$];

    // Shadow of written matrices, weights indexed [row][col]
    int     x_m  [num_tokens][num_feat];
    int     wq_m [num_feat][num_feat];
    int     wk_m [num_feat][num_feat];
    longint exp_score [num_tokens][num_tokens];

    attn_bridge_top #(
        .feed_gap (feed_gap)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .wr_a       (wr_a),
        .wr_b       (wr_b),
        .busy       (busy),
        .out_scores (out_scores)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Free-running cycle count, also the run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) begin
            $display("Timeout: simulation still running after %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "Simulation timeout");
        end
    end

    // Score rows with their cycle, counted from the edge that takes start
    always @(negedge clk) begin
        if (out_scores.valid) begin
            rows_q.push_back(out_scores);
            row_cyc_q.push_back(cyc - start_cyc);
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Four signed bytes, full range
    function automatic row_word_t random_word();
        row_word_t   w;
        logic [31:0] r;
        r = next_rand();
        for (int d = 0; d < num_feat; d++) begin
            w[d] = in_elem_t'(r[in_width*d +: in_width]);
        end
        return w;
    endfunction

    // Column c of the identity, 1.0 = 16
    function automatic row_word_t identity_word(int c);
        row_word_t w;
        for (int d = 0; d < num_feat; d++) begin
            w[d] = (d == c) ? in_elem_t'(1 << in_frac) : '0;
        end
        return w;
    endfunction

    function automatic wr_cmd_t make_cmd(int addr, row_word_t data, logic we);
        wr_cmd_t cmd;
        cmd.en   = 1'b1;
        cmd.we   = we;
        cmd.addr = addr_width'(addr);
        cmd.data = data;
        return cmd;
    endfunction

    // Address map: X rows, Wq columns, Wk columns, rest dropped
    function automatic void apply_word(int addr, row_word_t data);
        for (int d = 0; d < num_feat; d++) begin
            if (addr < wq_base) begin
                x_m[addr - x_base][d] = int'(data[d]);
            end else if (addr < wk_base) begin
                wq_m[d][addr - wq_base] = int'(data[d]);
            end else if (addr < mem_words) begin
                wk_m[d][addr - wk_base] = int'(data[d]);
            end
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fail_run(string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic check_value(string what, longint expected, longint actual);
        if (expected !== actual) begin
            $display("FAILED at %0t: %s expected %0d got %0d", $time, what, expected, actual);
            $display("Test failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    // One cycle on both ports, port b lands last in the shadow
    task automatic write_ports(wr_cmd_t a, wr_cmd_t b);
        next_cycle();
        wr_a = a;
        wr_b = b;
        if (a.en && a.we) apply_word(int'(a.addr), a.data);
        if (b.en && b.we) apply_word(int'(b.addr), b.data);
    endtask

    task automatic clear_ports();
        next_cycle();
        wr_a = '0;
        wr_b = '0;
    endtask

    // X through port a, weights through port b
    task automatic load_matrices(bit load_x, bit identity_w);
        for (int w = 0; w < num_feat; w++) begin
            write_ports(load_x ? make_cmd(x_base + w, random_word(), 1'b1) : '0,
                make_cmd(wq_base + w, identity_w ? identity_word(w) : random_word(), 1'b1));
        end
        for (int w = 0; w < num_feat; w++) begin
            write_ports('0,
                make_cmd(wk_base + w, identity_w ? identity_word(w) : random_word(), 1'b1));
        end
        clear_ports();
    endtask

    // Q/K projection then Q times K transposed, both rescaled
    task automatic build_expected();
        longint q [num_tokens][num_feat];
        longint k [num_tokens][num_feat];
        longint sq;
        longint sk;
        for (int i = 0; i < num_tokens; i++) begin
            for (int c = 0; c < num_feat; c++) begin
                sq = 0;
                sk = 0;
                for (int d = 0; d < num_feat; d++) begin
                    sq += longint'(x_m[i][d]) * wq_m[d][c];
                    sk += longint'(x_m[i][d]) * wk_m[d][c];
                end
                q[i][c] = longint'(shortint'(sq >>> in_frac));
                k[i][c] = longint'(shortint'(sk >>> in_frac));
            end
        end
        for (int i = 0; i < num_tokens; i++) begin
            for (int j = 0; j < num_tokens; j++) begin
                sq = 0;
                for (int d = 0; d < num_feat; d++) begin
                    sq += q[i][d] * k[j][d];
                end
                exp_score[i][j] = longint'(int'(sq >>> shift_amount));
            end
        end
    endtask

    task automatic start_run();
        next_cycle();
        rows_q.delete();
        row_cyc_q.delete();
        start     = 1'b1;
        start_cyc = cyc + 1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic collect_and_check(string name);
        int         waited;
        score_row_t row;
        waited = 0;
        build_expected();
        while ((rows_q.size() < num_tokens) && (waited < row_wait)) begin
            @(posedge clk);
            waited++;
        end
        if (rows_q.size() < num_tokens) begin
            fail_run($sformatf("%s: only %0d of %0d score rows arrived",
                name, rows_q.size(), num_tokens));
        end
        // A surplus row would come within one row period
        repeat (num_feat + feed_gap + 2) @(posedge clk);
        @(negedge clk);
        if (rows_q.size() != num_tokens) begin
            fail_run($sformatf("%s: %0d score rows instead of %0d",
                name, rows_q.size(), num_tokens));
        end
        check_value({name, ": busy after run"}, 0, busy);
        for (int r = 0; r < num_tokens; r++) begin
            row = rows_q[r];
            if (int'(row.index) != r) begin
                fail_run($sformatf("%s: score row %0d arrived in position %0d", name,
                    row.index, r));
            end
            check_value($sformatf("%s: row %0d cycle", name, r),
                num_tokens + 1 + (r + 1) * num_feat + r * feed_gap + 1, row_cyc_q[r]);
            for (int j = 0; j < num_tokens; j++) begin
                check_value($sformatf("%s: score[%0d][%0d]", name, r, j),
                    exp_score[r][j], longint'($signed(row.score[j])));
            end
        end
    endtask

    task automatic test_identity();
        load_matrices(1'b1, 1'b1);
        start_run();
        collect_and_check("identity weights");
    endtask

    task automatic test_random();
        load_matrices(1'b1, 1'b0);
        start_run();
        collect_and_check("random data");
    endtask

    task automatic test_port_collision();
        // Same Wq column from both ports
        write_ports(make_cmd(wq_base + 1, random_word(), 1'b1),
            make_cmd(wq_base + 1, random_word(), 1'b1));
        // Enabled but not writing
        write_ports(make_cmd(x_base + 2, random_word(), 1'b0),
            make_cmd(wk_base + 3, random_word(), 1'b0));
        clear_ports();
        start_run();
        collect_and_check("port collision");
    endtask

    task automatic test_back_to_back();
        start_run();
        // Up to the final feed beat, the last cycle with busy high
        repeat (last_beat) next_cycle();
        check_value("busy while feeding", 1, busy);
        // Start while busy is still high, its rows must be dropped
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        collect_and_check("first run");
        load_matrices(1'b0, 1'b0);
        start_run();
        collect_and_check("second run");
    endtask

    task automatic test_row_timing();
        repeat (3) next_cycle();
        start_run();
        collect_and_check("row timing");
    endtask

    task automatic test_reset_mid_run();
        start_run();
        repeat (6) next_cycle();
        rst_n = 1'b0;
        repeat (3) next_cycle();
        rst_n = 1'b1;
        repeat (8) begin
            next_cycle();
            check_value("valid after reset", 0, out_scores.valid);
            check_value("busy after reset", 0, busy);
        end
        check_value("rows across reset", 0, rows_q.size());
        start_run();
        collect_and_check("after reset");
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        wr_a  = '0;
        wr_b  = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_identity();
        test_random();
        test_port_collision();
        test_back_to_back();
        test_row_timing();
        test_reset_mid_run();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: source/attn_bridge_top.sv
// --------------------------------------------------
// Attention bridge top: projection, bridge buffer,
// score matmul and right shift in one chain
// --------------------------------------------------
module attn_bridge_top
    import attn_layout_pkg::*;
#(
    parameter int feed_gap = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  wr_cmd_t    wr_a,
    input  wr_cmd_t    wr_b,
    output logic       busy,
    output score_row_t out_scores
);

    // Q/K rows from the projection
    proj_row_t  proj;

    // Beats into the matmul
    feed_t      feed;

    // Raw accumulators before rescale
    score_row_t acc_row;

    // Projection, done pulse not needed downstream
    linear_projection u_proj (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .wr_a  (wr_a),
        .wr_b  (wr_b),
        .proj  (proj),
        .done  ()
    );

    // Bridge buffer, busy goes straight out
    bridge_buffer #(
        .feed_gap (feed_gap)
    ) u_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .proj  (proj),
        .feed  (feed),
        .busy  (busy)
    );

    // Q times K transposed
    score_matmul u_matmul (
        .clk     (clk),
        .rst_n   (rst_n),
        .feed    (feed),
        .acc_row (acc_row)
    );

    // Rescale by 4 bits
    score_rshift u_rshift (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc_row    (acc_row),
        .out_scores (out_scores)
    );

endmodule

// File: source/attn_fixed_pkg.sv
// --------------------------------------------------
// Fixed-point formats and element types for inputs,
// Q/K projections, accumulators and scores
// --------------------------------------------------
package attn_fixed_pkg;

    // X, Wq and Wk elements
    // 8-bit signed, 4 fraction bits
    localparam int in_width = 8;
    localparam int in_frac  = 4;

    // Q and K elements after projection
    // Sum of products shifted back by in_frac, low 16 bits kept
    localparam int proj_width = 16;
    localparam int proj_frac  = 4;

    // Score elements leaving the rescale stage
    localparam int score_width = 32;

    // Q*K product carries 2*proj_frac fraction bits
    // Dropping proj_frac of them restores the 4-bit fraction
    localparam int shift_amount = proj_frac;

    // Accumulator width, with headroom over D products of two proj_width values
    localparam int acc_width = 40;

    // Signed element types
    typedef logic signed [in_width-1:0]    in_elem_t;
    typedef logic signed [proj_width-1:0]  proj_elem_t;
    typedef logic signed [score_width-1:0] score_t;

    // Raw matmul accumulator
    typedef logic signed [acc_width-1:0]   acc_t;

endpackage

// File: source/attn_layout_pkg.sv
// --------------------------------------------------
// Matrix dimensions, write address map and the
// structs carrying rows, feed beats and commands
// --------------------------------------------------
package attn_layout_pkg;

    import attn_fixed_pkg::*;

    // N tokens, D features
    localparam int num_tokens = 4;
    localparam int num_feat   = 4;
    localparam int idx_width  = $clog2(num_tokens);
    localparam int feat_width = $clog2(num_feat);

    // Address map
    // X rows first, then Wq columns, then Wk columns, rest ignored
    localparam int addr_width = 4;
    localparam int x_base     = 0;
    localparam int wq_base    = x_base + num_tokens;
    localparam int wk_base    = wq_base + num_feat;
    localparam int mem_words  = wk_base + num_feat;

    // D input elements in one 32-bit word, element 0 in the low byte
    typedef in_elem_t [num_feat-1:0] row_word_t;

    // One Q or K row
    typedef proj_elem_t [num_feat-1:0] proj_vec_t;

    // Element d of every K row
    typedef proj_elem_t [num_tokens-1:0] key_col_t;

    // One score row, accumulator wide
    typedef acc_t [num_tokens-1:0] score_vec_t;

    // Single write port
    typedef struct packed {
        logic                  en;
        logic                  we;
        logic [addr_width-1:0] addr;
        row_word_t             data;
    } wr_cmd_t;

    // Projection output, Q[i] and K[i] together
    typedef struct packed {
        logic                 valid;
        logic [idx_width-1:0] index;
        proj_vec_t            q;
        proj_vec_t            k;
    } proj_row_t;

    // One matmul beat
    typedef struct packed {
        logic                 reset_acc;
        logic                 en;
        logic                 last;
        logic [idx_width-1:0] index;
        proj_elem_t           west;
        key_col_t             north;
    } feed_t;

    // Raw accumulators out of the matmul, rescaled values out of the shift
    typedef struct packed {
        logic                 valid;
        logic [idx_width-1:0] index;
        score_vec_t           score;
    } score_row_t;

endpackage

// File: source/bridge_buffer.sv
// --------------------------------------------------
// Bridge buffer: west bank of Q rows, north bank of
// K rows, and the beat sequencer for the matmul
// --------------------------------------------------
module bridge_buffer
    import attn_layout_pkg::*;
#(
    parameter int feed_gap = 0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  proj_row_t proj,
    output feed_t     feed,
    output logic      busy
);

    // Gap counter holds feed_gap-1 down to 0
    localparam int gap_width = (feed_gap > 1) ? $clog2(feed_gap) : 1;

    localparam logic [idx_width-1:0]  last_row  = idx_width'(num_tokens - 1);
    localparam logic [feat_width-1:0] last_feat = feat_width'(num_feat - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_collect,
        st_feed,
        st_gap
    } state_t;

    state_t                state;
    logic [1:0]            busy_q;
    logic [idx_width-1:0]  row_cnt;
    logic [feat_width-1:0] feat_cnt;
    logic [gap_width-1:0]  gap_cnt;
    logic                  row_accept;
    logic                  beat;

    // Banks indexed by row index
    proj_vec_t west_bank  [num_tokens];
    proj_vec_t north_bank [num_tokens];

    // New collection opens on row 0 only
    // Rows of a start issued while busy are dropped
    // Row 0 trails its start edge by one cycle, so busy is taken two cycles back
    assign row_accept = proj.valid &&
        ((state == st_collect) ||
         ((state == st_idle) && (proj.index == '0) && !busy_q[1]));

    assign busy = (state != st_idle);
    assign beat = (state == st_feed);

    // Q row to the west bank, K row to the north bank
    always_ff @(posedge clk) begin
        if (row_accept) begin
            west_bank[proj.index]  <= proj.q;
            north_bank[proj.index] <= proj.k;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            busy_q   <= '0;
            row_cnt  <= '0;
            feat_cnt <= '0;
            gap_cnt  <= '0;
        end else begin
            busy_q <= {busy_q[0], busy};
            case (state)
                st_idle, st_collect: begin
                    // Feeding starts right after row N-1 is stored
                    if (row_accept) begin
                        state <= (proj.index == last_row) ? st_feed : st_collect;
                    end
                    row_cnt  <= '0;
                    feat_cnt <= '0;
                end
                st_feed: begin
                    feat_cnt <= feat_cnt + 1'b1;
                    if (feat_cnt == last_feat) begin
                        // Score row finished
                        feat_cnt <= '0;
                        row_cnt  <= row_cnt + 1'b1;
                        if (row_cnt == last_row) begin
                            state <= st_idle;
                        end else if (feed_gap > 0) begin
                            state   <= st_gap;
                            gap_cnt <= gap_width'(feed_gap - 1);
                        end
                    end
                end
                st_gap: begin
                    // Idle cycles between score rows
                    gap_cnt <= gap_cnt - 1'b1;
                    if (gap_cnt == '0) begin
                        state <= st_feed;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Beat d of row r: Q[r][d] west, K[j][d] north for every j
    always_comb begin
        feed.en        = beat;
        feed.reset_acc = beat && (feat_cnt == '0);
        feed.last      = beat && (feat_cnt == last_feat);
        feed.index     = row_cnt;
        feed.west      = west_bank[row_cnt][feat_cnt];
        for (int j = 0; j < num_tokens; j++) begin
            feed.north[j] = north_bank[j][feat_cnt];
        end
    end

endmodule

// File: source/linear_projection.sv
// --------------------------------------------------
// Linear projection: dual-port X/Wq/Wk storage and
// the Q/K row computation, one row per cycle
// --------------------------------------------------
module linear_projection
    import attn_fixed_pkg::*, attn_layout_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  wr_cmd_t   wr_a,
    input  wr_cmd_t   wr_b,
    output proj_row_t proj,
    output logic      done
);

    // Full precision sum of D products of two in_width values
    localparam int sum_width = 2 * in_width + $clog2(num_feat);

    localparam logic [idx_width-1:0] last_row = idx_width'(num_tokens - 1);

    // X rows, Wq columns, Wk columns
    row_word_t mem [mem_words];

    logic                 running;
    logic [idx_width-1:0] row_cnt;
    row_word_t            x_row;
    proj_vec_t            q_next;
    proj_vec_t            k_next;

    // One element of Q or K
    // X row against a weight column, then back to the projection format
    function automatic proj_elem_t dot_rescale(row_word_t x_vec, row_word_t w_vec);
        logic signed [sum_width-1:0] sum;
        sum = '0;
        for (int d = 0; d < num_feat; d++) begin
            sum = sum + $signed(x_vec[d]) * $signed(w_vec[d]);
        end
        // Arithmetic shift drops in_frac bits
        // Low proj_width bits kept
        return proj_elem_t'(sum >>> in_frac);
    endfunction

    // Two write ports
    // Port b goes last, so it wins when both hit one address
    always_ff @(posedge clk) begin
        if (wr_a.en && wr_a.we && (wr_a.addr < addr_width'(mem_words))) begin
            mem[wr_a.addr] <= wr_a.data;
        end
        if (wr_b.en && wr_b.we && (wr_b.addr < addr_width'(mem_words))) begin
            mem[wr_b.addr] <= wr_b.data;
        end
    end

    // X row selected by the row counter
    assign x_row = mem[x_base + int'(row_cnt)];

    // D x D multiplies per matrix
    always_comb begin
        for (int c = 0; c < num_feat; c++) begin
            q_next[c] = dot_rescale(x_row, mem[wq_base + c]);
            k_next[c] = dot_rescale(x_row, mem[wk_base + c]);
        end
    end

    // Run control
    // Row i leaves i+1 cycles after the start edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running    <= 1'b0;
            row_cnt    <= '0;
            proj.valid <= 1'b0;
            done       <= 1'b0;
        end else begin
            proj.valid <= running;
            // Done rides with the last row
            done       <= running && (row_cnt == last_row);
            if (running) begin
                row_cnt <= row_cnt + 1'b1;
                if (row_cnt == last_row) begin
                    running <= 1'b0;
                end
            end else if (start) begin
                // Start only counts while idle
                running <= 1'b1;
                row_cnt <= '0;
            end
        end
        // Row payload
        proj.index <= row_cnt;
        proj.q     <= q_next;
        proj.k     <= k_next;
    end

endmodule

// File: source/score_matmul.sv
// --------------------------------------------------
// Score matmul: N multiply-accumulate lanes, one
// row of Q times K transposed per D beats
// --------------------------------------------------
module score_matmul
    import attn_fixed_pkg::*, attn_layout_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  feed_t      feed,
    output score_row_t acc_row
);

    // Lane products at accumulator width
    acc_t prod [num_tokens];

    // Lane j: west element times north element j
    // Both operands signed, extended before the multiply
    always_comb begin
        for (int j = 0; j < num_tokens; j++) begin
            prod[j] = $signed(feed.west) * $signed(feed.north[j]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_row.valid <= 1'b0;
        end else begin
            // Row complete once its last beat is in
            acc_row.valid <= feed.en && feed.last;
        end

        // Row index captured with the last beat
        if (feed.en && feed.last) begin
            acc_row.index <= feed.index;
        end

        // First beat of a row loads, later beats add
        for (int j = 0; j < num_tokens; j++) begin
            if (feed.en) begin
                if (feed.reset_acc) begin
                    acc_row.score[j] <= prod[j];
                end else begin
                    acc_row.score[j] <= acc_row.score[j] + prod[j];
                end
            end
        end
    end

endmodule

// File: source/score_rshift.sv
// --------------------------------------------------
// Registered arithmetic right shift of a score row
// --------------------------------------------------
module score_rshift
    import attn_fixed_pkg::*, attn_layout_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  score_row_t acc_row,
    output score_row_t out_scores
);

    score_t shifted [num_tokens];

    // Drop shift_amount fraction bits, keep score_width bits
    always_comb begin
        for (int j = 0; j < num_tokens; j++) begin
            shifted[j] = score_t'($signed(acc_row.score[j]) >>> shift_amount);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_scores.valid <= 1'b0;
        end else begin
            out_scores.valid <= acc_row.valid;
        end
        out_scores.index <= acc_row.index;
        // Sign-extended back into the accumulator-wide field
        for (int j = 0; j < num_tokens; j++) begin
            out_scores.score[j] <= shifted[j];
        end
    end

endmodule

// File: src.f
source/attn_fixed_pkg.sv
source/attn_layout_pkg.sv
source/linear_projection.sv
source/bridge_buffer.sv
source/score_matmul.sv
source/score_rshift.sv
source/attn_bridge_top.sv
dv/tb_attn_bridge.sv
